//--- dv/peripheral_subsystem_tb.sv
// Peripheral subsystem testbench with bus tasks, LFSR stimulus and claim reference model
// Response checker on every rvalid and a cycle timeout

`timescale 1ns/1ns

module peripheral_subsystem_tb;

  // Tests take about 200 cycles
  localparam int MAX_CYCLES = 400;

  logic                              clk;
  logic                              rst;
  periph_pkg::bus_req_t              bus_req;
  periph_pkg::bus_rsp_t              bus_rsp;
  logic [periph_pkg::NEXT_INT-1:0]   intr_ext;
  logic                              irq;
  logic                              msip;
  logic [periph_pkg::GPIO_W-1:0]     gpio_in;
  logic [periph_pkg::GPIO_W-1:0]     gpio_out;
  logic [periph_pkg::GPIO_W-1:0]     gpio_oe;
  logic                              timer_intr;

  logic [31:0] lfsr_q;
  logic [31:0] exp_q[$];
  logic [31:0] addr_q[$];
  bit          chk_q[$];
  logic [31:0] rsp_exp;
  logic [31:0] rsp_addr;
  bit          rsp_chk;
  logic [31:0] last_rdata;
  logic        accepted_q;
  int          issued = 0;
  int          done_cnt = 0;
  int          cycles = 0;
  int          rdata_errs = 0;
  int          resp_errs = 0;
  int          gnt_errs = 0;
  int          out_errs = 0;

  // Software view of the interrupt sources
  logic [periph_pkg::GPIO_W-1:0]  pins_m;
  logic [periph_pkg::GPIO_W-1:0]  inten_m;
  logic [periph_pkg::NUM_SRC-1:0] en_m;
  logic [periph_pkg::NUM_SRC-1:0] busy_m;

  peripheral_subsystem UUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .intr_ext_i  (intr_ext),
    .irq_o       (irq),
    .msip_o      (msip),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .timer_intr_o(timer_intr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    accepted_q <= !rst && bus_req.req;
    // Grant follows the request in the same cycle
    if (bus_rsp.gnt !== bus_req.req) begin
      $display("FAIL gnt: got %h, expected %h", bus_rsp.gnt, bus_req.req);
      gnt_errs++;
    end
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d rdata, %0d response, %0d grant, %0d output errors",
               cycles, rdata_errs, resp_errs, gnt_errs, out_errs);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // One response owed per accepted request
  always @(negedge clk) begin
    if (accepted_q) begin
      rsp_exp  = exp_q.pop_front();
      rsp_addr = addr_q.pop_front();
      rsp_chk  = chk_q.pop_front();
      if (bus_rsp.rvalid !== 1'b1) begin
        $display("No response arrived for the access to address %h", rsp_addr);
        resp_errs++;
      end else if (rsp_chk && bus_rsp.rdata !== rsp_exp) begin
        $display("FAIL rdata at %h: got %h, expected %h", rsp_addr, bus_rsp.rdata, rsp_exp);
        rdata_errs++;
      end
      last_rdata = bus_rsp.rdata;
      done_cnt++;
    end else if (bus_rsp.rvalid !== 1'b0) begin
      $display("Response arrived with no access outstanding");
      resp_errs++;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  function automatic logic [31:0] any_addr(input logic [15:0] tag, input logic [3:0] idx,
                                           input logic [3:0] off);
    periph_pkg::periph_addr_u a;
    a.raw = '0;
    a.fld.tag = tag;
    a.fld.index = idx;
    a.fld.offset = off;
    return a.raw;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] idx, input logic [3:0] off);
    return any_addr(periph_pkg::PERIPH_TAG, idx, off);
  endfunction

  // Id 0 low, 1..16 pins, 17 timer kept low here, 18..21 external
  function automatic logic [periph_pkg::NUM_SRC-1:0] model_src();
    return {intr_ext, 1'b0, pins_m & inten_m, 1'b0};
  endfunction

  // Lowest source that is high, enabled and not yet claimed
  function automatic logic [periph_pkg::SRC_IDW-1:0] ref_claim(
      input logic [periph_pkg::NUM_SRC-1:0] src, input logic [periph_pkg::NUM_SRC-1:0] en,
      input logic [periph_pkg::NUM_SRC-1:0] busy);
    logic [periph_pkg::SRC_IDW-1:0] id;
    id = '0;
    for (int i = 1; i < periph_pkg::NUM_SRC; i++) begin
      if (id == '0 && src[i] && en[i] && !busy[i]) begin
        id = periph_pkg::SRC_IDW'(i);
      end
    end
    return id;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("FAIL %s: got %h, expected %h", name, got, want);
      out_errs++;
    end
  endtask

  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [31:0] exp_val, input bit chk);
    @(negedge clk);
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    exp_q.push_back(we ? 32'h0 : exp_val);
    addr_q.push_back(addr);
    chk_q.push_back(chk);
    issued++;
  endtask

  task automatic drain();
    @(negedge clk);
    bus_req = '0;
    wait (done_cnt == issued);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    issue(1'b1, addr, data, 32'h0, 1'b1);
    drain();
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp_val);
    issue(1'b0, addr, 32'h0, exp_val, 1'b1);
    drain();
  endtask

  task automatic read_value(input logic [31:0] addr, output logic [31:0] data);
    issue(1'b0, addr, 32'h0, 32'h0, 1'b0);
    drain();
    data = last_rdata;
  endtask

  initial begin
    logic [31:0]                    wdat [4];
    logic [31:0]                    regs [4];
    logic [31:0]                    masks [4];
    logic [31:0]                    rnd;
    logic [31:0]                    data;
    logic [periph_pkg::SRC_IDW-1:0] exp_id;
    int                             polls;
    rst = 1'b1;
    bus_req = '0;
    intr_ext = '0;
    gpio_in = '0;
    lfsr_q = 32'h6ee7;
    pins_m = '0;
    inten_m = '0;
    en_m = '0;
    busy_m = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    expect_eq("rvalid", 32'(bus_rsp.rvalid), 32'h0);
    expect_eq("rdata", bus_rsp.rdata, 32'h0);
    expect_eq("irq_o", 32'(irq), 32'h0);
    expect_eq("msip_o", 32'(msip), 32'h0);
    expect_eq("gpio_o", 32'(gpio_out), 32'h0);
    expect_eq("gpio_oe_o", 32'(gpio_oe), 32'h0);
    expect_eq("timer_intr_o", 32'(timer_intr), 32'h0);

    // Back-to-back writes then reads
    regs[0] = reg_addr(periph_pkg::GPIO_IDX, periph_pkg::GPIO_OUT);
    regs[1] = reg_addr(periph_pkg::GPIO_IDX, periph_pkg::GPIO_OE);
    regs[2] = reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_COMPARE);
    regs[3] = reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_ENABLE);
    masks[0] = 32'h0000_ffff;
    masks[1] = 32'h0000_ffff;
    masks[2] = 32'hffff_ffff;
    masks[3] = 32'h003f_ffff;
    for (int i = 0; i < 4; i++) begin
      wdat[i] = rand_bits(32);
      issue(1'b1, regs[i], wdat[i], 32'h0, 1'b1);
    end
    for (int i = 0; i < 4; i++) begin
      issue(1'b0, regs[i], 32'h0, wdat[i] & masks[i], 1'b1);
    end
    drain();
    expect_eq("gpio_o", 32'(gpio_out), wdat[0] & masks[0]);
    expect_eq("gpio_oe_o", 32'(gpio_oe), wdat[1] & masks[1]);
    en_m = wdat[3][periph_pkg::NUM_SRC-1:0];

    // Misses on a foreign tag and on index 3 and above
    issue(1'b1, any_addr(16'h3000, periph_pkg::GPIO_IDX, periph_pkg::GPIO_OUT), ~wdat[0],
          32'h0, 1'b1);
    issue(1'b1, reg_addr(4'd5, periph_pkg::GPIO_OUT), ~wdat[0], 32'h0, 1'b1);
    issue(1'b0, reg_addr(4'd4, periph_pkg::PLIC_ENABLE), 32'h0, 32'h0, 1'b1);
    issue(1'b0, any_addr(16'h2001, periph_pkg::PLIC_IDX, periph_pkg::PLIC_ENABLE), 32'h0,
          32'h0, 1'b1);
    issue(1'b0, regs[0], 32'h0, wdat[0] & masks[0], 1'b1);
    drain();
    expect_eq("gpio_o", 32'(gpio_out), wdat[0] & masks[0]);

    // GPIO input path and pin interrupts
    for (int i = 0; i < 4; i++) begin
      rnd = rand_bits(16);
      @(negedge clk);
      gpio_in = rnd[15:0];
      pins_m = rnd[15:0];
      repeat (2) @(negedge clk);
      read_check(reg_addr(periph_pkg::GPIO_IDX, periph_pkg::GPIO_IN), 32'(pins_m));
    end
    rnd = rand_bits(16);
    inten_m = rnd[15:0];
    write_reg(reg_addr(periph_pkg::GPIO_IDX, periph_pkg::GPIO_INTEN), 32'(inten_m));
    read_check(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_PENDING), 32'(model_src()));

    // Timer expiry, interrupt and clear
    write_reg(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_COMPARE), 32'd40);
    write_reg(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_COUNT), 32'd0);
    write_reg(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_CTRL), 32'h3);
    polls = 0;
    data = '0;
    while (data[0] !== 1'b1 && polls < 60) begin
      read_value(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_STATUS), data);
      polls++;
    end
    if (data[0] !== 1'b1) begin
      $display("Timer status never showed expiry within %0d polls", polls);
      out_errs++;
    end
    read_value(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_COUNT), data);
    if (data < 32'd40) begin
      $display("FAIL TMR_COUNT: got %h, expected at least %h", data, 32'd40);
      out_errs++;
    end
    expect_eq("timer_intr_o", 32'(timer_intr), 32'h1);
    write_reg(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_STATUS), 32'h1);
    expect_eq("timer_intr_o", 32'(timer_intr), 32'h0);
    read_check(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_STATUS), 32'h0);
    write_reg(reg_addr(periph_pkg::TIMER_IDX, periph_pkg::TMR_CTRL), 32'h0);

    // External line 0 always takes part in the claim walk
    rnd = rand_bits(4);
    @(negedge clk);
    intr_ext = rnd[3:0] | 4'b0001;
    rnd = rand_bits(periph_pkg::NUM_SRC);
    en_m = rnd[periph_pkg::NUM_SRC-1:0] | 22'h04_0000;
    write_reg(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_ENABLE), 32'(en_m));
    exp_id = 5'd1;
    for (int n = 0; n <= periph_pkg::NUM_SRC && exp_id != 5'd0; n++) begin
      exp_id = ref_claim(model_src(), en_m, busy_m);
      expect_eq("irq_o", 32'(irq), 32'(exp_id != 5'd0));
      read_check(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_CLAIM), 32'(exp_id));
      if (exp_id != 5'd0) begin
        busy_m[exp_id] = 1'b1;
      end
    end
    expect_eq("irq_o", 32'(irq), 32'h0);

    // Complete id 18 while its line stays high
    write_reg(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_CLAIM), 32'd18);
    busy_m[18] = 1'b0;
    expect_eq("irq_o", 32'(irq), 32'h1);
    read_check(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_CLAIM),
               32'(ref_claim(model_src(), en_m, busy_m)));
    busy_m[18] = 1'b1;

    write_reg(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_MSIP), 32'h1);
    expect_eq("msip_o", 32'(msip), 32'h1);
    read_check(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_MSIP), 32'h1);
    write_reg(reg_addr(periph_pkg::PLIC_IDX, periph_pkg::PLIC_MSIP), 32'h0);
    expect_eq("msip_o", 32'(msip), 32'h0);

    $display("Errors: %0d rdata, %0d response, %0d grant, %0d output",
             rdata_errs, resp_errs, gnt_errs, out_errs);
    if (rdata_errs == 0 && resp_errs == 0 && gnt_errs == 0 && out_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- logic/periph_gpio.sv
// GPIO block with two-flop input synchronizer
// Output, output enable and level interrupt enable registers

`timescale 1ns/1ns

module periph_gpio (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  periph_pkg::reg_req_t              reg_req_i,
  input  logic                              sel_i,
  input  logic [periph_pkg::GPIO_W-1:0]     gpio_i,
  output logic [periph_pkg::BUS_DW-1:0]     rdata_o,
  output logic [periph_pkg::GPIO_W-1:0]     gpio_o,
  output logic [periph_pkg::GPIO_W-1:0]     gpio_oe_o,
  output logic [periph_pkg::GPIO_W-1:0]     gpio_intr_o
);

  logic [periph_pkg::GPIO_W-1:0] sync_q1;
  logic [periph_pkg::GPIO_W-1:0] sync_q2;
  logic [periph_pkg::GPIO_W-1:0] out_q;
  logic [periph_pkg::GPIO_W-1:0] oe_q;
  logic [periph_pkg::GPIO_W-1:0] inten_q;
  logic                          wr_en;

  assign wr_en = reg_req_i.valid && sel_i && reg_req_i.write;

  // Pins are asynchronous to clk_i
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      inten_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.offset)
        periph_pkg::GPIO_OUT:   out_q   <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
        periph_pkg::GPIO_OE:    oe_q    <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
        periph_pkg::GPIO_INTEN: inten_q <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_req_i.offset)
      periph_pkg::GPIO_IN:    rdata_o = periph_pkg::BUS_DW'(sync_q2);
      periph_pkg::GPIO_OUT:   rdata_o = periph_pkg::BUS_DW'(out_q);
      periph_pkg::GPIO_OE:    rdata_o = periph_pkg::BUS_DW'(oe_q);
      periph_pkg::GPIO_INTEN: rdata_o = periph_pkg::BUS_DW'(inten_q);
      default:                rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

  // Level interrupt per pin
  assign gpio_intr_o = sync_q2 & inten_q;

endmodule

//--- logic/periph_pkg.sv
// Shared sizes, address map and register offsets of the peripheral subsystem
// Bus, register access and address decode types

package periph_pkg;

  localparam int BUS_DW   = 32;
  localparam int GPIO_W   = 16;
  localparam int NEXT_INT = 4;

  // Id 0 reserved, 1..16 GPIO, 17 timer, 18..21 external
  localparam int NUM_SRC = 22;
  localparam int SRC_IDW = 5;

  localparam logic [15:0] PERIPH_TAG = 16'h2000;

  localparam logic [3:0] PLIC_IDX   = 4'd0;
  localparam logic [3:0] GPIO_IDX   = 4'd1;
  localparam logic [3:0] TIMER_IDX  = 4'd2;
  localparam logic [3:0] NUM_PERIPH = 4'd3;

  // Word offsets inside each peripheral
  localparam logic [3:0] PLIC_PENDING = 4'd0;
  localparam logic [3:0] PLIC_ENABLE  = 4'd1;
  localparam logic [3:0] PLIC_CLAIM   = 4'd2;
  localparam logic [3:0] PLIC_MSIP    = 4'd3;

  localparam logic [3:0] GPIO_IN    = 4'd0;
  localparam logic [3:0] GPIO_OUT   = 4'd1;
  localparam logic [3:0] GPIO_OE    = 4'd2;
  localparam logic [3:0] GPIO_INTEN = 4'd3;

  localparam logic [3:0] TMR_COUNT   = 4'd0;
  localparam logic [3:0] TMR_COMPARE = 4'd1;
  localparam logic [3:0] TMR_CTRL    = 4'd2;
  localparam logic [3:0] TMR_STATUS  = 4'd3;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [31:0]       addr;
    logic [BUS_DW-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [BUS_DW-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [3:0]        offset;
    logic [BUS_DW-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [15:0] tag;
    logic [3:0]  index;
    logic [5:0]  unused;
    logic [3:0]  offset;
    logic [1:0]  byte_off;
  } periph_addr_fields_t;

  // Same address word, raw or split into decode fields
  typedef union packed {
    logic [31:0]         raw;
    periph_addr_fields_t fld;
  } periph_addr_u;

endpackage

//--- logic/periph_plic.sv
// Level-triggered interrupt controller with claim and complete
// Lowest eligible source id wins, plus a software interrupt bit

`timescale 1ns/1ns

module periph_plic (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  periph_pkg::reg_req_t              reg_req_i,
  input  logic                              sel_i,
  input  logic [periph_pkg::NUM_SRC-1:0]    intr_src_i,
  output logic [periph_pkg::BUS_DW-1:0]     rdata_o,
  output logic                              irq_o,
  output logic                              msip_o
);

  logic [periph_pkg::NUM_SRC-1:0] pending;
  logic [periph_pkg::NUM_SRC-1:0] enable_q;
  logic [periph_pkg::NUM_SRC-1:0] in_prog_q;
  logic [periph_pkg::NUM_SRC-1:0] eligible;
  logic [periph_pkg::SRC_IDW-1:0] claim_id;
  logic [periph_pkg::SRC_IDW-1:0] cmpl_id;
  logic                           msip_q;
  logic                           wr_en;
  logic                           rd_en;

  // Id 0 never pends
  assign pending  = intr_src_i & ~periph_pkg::NUM_SRC'(1);
  assign eligible = pending & enable_q & ~in_prog_q;

  // Descending scan so the lowest id is the one left standing
  always_comb begin
    claim_id = '0;
    for (int i = periph_pkg::NUM_SRC - 1; i >= 1; i--) begin
      if (eligible[i]) begin
        claim_id = periph_pkg::SRC_IDW'(i);
      end
    end
  end

  assign wr_en   = reg_req_i.valid && sel_i && reg_req_i.write;
  assign rd_en   = reg_req_i.valid && sel_i && !reg_req_i.write;
  assign cmpl_id = reg_req_i.wdata[periph_pkg::SRC_IDW-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q  <= '0;
      in_prog_q <= '0;
      msip_q    <= 1'b0;
    end else begin
      if (wr_en && reg_req_i.offset == periph_pkg::PLIC_ENABLE) begin
        enable_q <= reg_req_i.wdata[periph_pkg::NUM_SRC-1:0];
      end
      if (wr_en && reg_req_i.offset == periph_pkg::PLIC_MSIP) begin
        msip_q <= reg_req_i.wdata[0];
      end
      // Claim on read, complete on write
      if (rd_en && reg_req_i.offset == periph_pkg::PLIC_CLAIM && claim_id != '0) begin
        in_prog_q[claim_id] <= 1'b1;
      end
      if (wr_en && reg_req_i.offset == periph_pkg::PLIC_CLAIM
          && cmpl_id < periph_pkg::SRC_IDW'(periph_pkg::NUM_SRC)) begin
        in_prog_q[cmpl_id] <= 1'b0;
      end
    end
  end

  always_comb begin
    case (reg_req_i.offset)
      periph_pkg::PLIC_PENDING: rdata_o = periph_pkg::BUS_DW'(pending);
      periph_pkg::PLIC_ENABLE:  rdata_o = periph_pkg::BUS_DW'(enable_q);
      periph_pkg::PLIC_CLAIM:   rdata_o = periph_pkg::BUS_DW'(claim_id);
      periph_pkg::PLIC_MSIP:    rdata_o = periph_pkg::BUS_DW'(msip_q);
      default:                  rdata_o = '0;
    endcase
  end

  assign irq_o  = (claim_id != '0);
  assign msip_o = msip_q;

endmodule

//--- logic/periph_timer.sv
// Free-running compare timer with sticky expiry flag
// CTRL holds run and interrupt enable, STATUS is write-one-to-clear

`timescale 1ns/1ns

module periph_timer (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  periph_pkg::reg_req_t              reg_req_i,
  input  logic                              sel_i,
  output logic [periph_pkg::BUS_DW-1:0]     rdata_o,
  output logic                              timer_intr_o
);

  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic        run_q;
  logic        ie_q;
  logic        expired_q;
  logic        wr_en;
  logic        match;

  assign wr_en = reg_req_i.valid && sel_i && reg_req_i.write;
  assign match = run_q && (count_q == compare_q);

  // Counter load has priority over increment
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (wr_en && reg_req_i.offset == periph_pkg::TMR_COUNT) begin
      count_q <= reg_req_i.wdata;
    end else if (run_q) begin
      count_q <= count_q + 32'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      compare_q <= '0;
      run_q     <= 1'b0;
      ie_q      <= 1'b0;
    end else if (wr_en) begin
      if (reg_req_i.offset == periph_pkg::TMR_COMPARE) begin
        compare_q <= reg_req_i.wdata;
      end
      if (reg_req_i.offset == periph_pkg::TMR_CTRL) begin
        run_q <= reg_req_i.wdata[0];
        ie_q  <= reg_req_i.wdata[1];
      end
    end
  end

  // A match in the same cycle beats the clear
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      expired_q <= 1'b0;
    end else if (match) begin
      expired_q <= 1'b1;
    end else if (wr_en && reg_req_i.offset == periph_pkg::TMR_STATUS && reg_req_i.wdata[0]) begin
      expired_q <= 1'b0;
    end
  end

  always_comb begin
    case (reg_req_i.offset)
      periph_pkg::TMR_COUNT:   rdata_o = count_q;
      periph_pkg::TMR_COMPARE: rdata_o = compare_q;
      periph_pkg::TMR_CTRL:    rdata_o = {30'b0, ie_q, run_q};
      periph_pkg::TMR_STATUS:  rdata_o = {31'b0, expired_q};
      default:                 rdata_o = '0;
    endcase
  end

  assign timer_intr_o = expired_q && ie_q;

endmodule

//--- logic/periph_xbar.sv
// Address decoder and demultiplexer from the bus port to the peripherals
// Registered read response path

`timescale 1ns/1ns

module periph_xbar (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  periph_pkg::bus_req_t                 bus_req_i,
  output periph_pkg::bus_rsp_t                 bus_rsp_o,
  output periph_pkg::reg_req_t                 reg_req_o,
  output logic                                 plic_sel_o,
  output logic                                 gpio_sel_o,
  output logic                                 tmr_sel_o,
  input  logic [periph_pkg::BUS_DW-1:0]        plic_rdata_i,
  input  logic [periph_pkg::BUS_DW-1:0]        gpio_rdata_i,
  input  logic [periph_pkg::BUS_DW-1:0]        tmr_rdata_i
);

  periph_pkg::periph_addr_u addr_u;

  logic                          hit;
  logic [periph_pkg::BUS_DW-1:0] rd_mux;
  logic                          rvalid_q;
  logic [periph_pkg::BUS_DW-1:0] rdata_q;

  assign addr_u.raw = bus_req_i.addr;

  // Only our tag and an existing index reach a peer
  assign hit = bus_req_i.req
             && (addr_u.fld.tag == periph_pkg::PERIPH_TAG)
             && (addr_u.fld.index < periph_pkg::NUM_PERIPH);

  assign plic_sel_o = hit && (addr_u.fld.index == periph_pkg::PLIC_IDX);
  assign gpio_sel_o = hit && (addr_u.fld.index == periph_pkg::GPIO_IDX);
  assign tmr_sel_o  = hit && (addr_u.fld.index == periph_pkg::TIMER_IDX);

  assign reg_req_o.valid  = hit;
  assign reg_req_o.write  = bus_req_i.we;
  assign reg_req_o.offset = addr_u.fld.offset;
  assign reg_req_o.wdata  = bus_req_i.wdata;

  always_comb begin
    rd_mux = '0;
    if (plic_sel_o) begin
      rd_mux = plic_rdata_i;
    end else if (gpio_sel_o) begin
      rd_mux = gpio_rdata_i;
    end else if (tmr_sel_o) begin
      rd_mux = tmr_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
    end
  end

  // Writes and misses answer with zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= bus_req_i.we ? '0 : rd_mux;
    end
  end

  assign bus_rsp_o.gnt    = bus_req_i.req;
  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.rdata  = rdata_q;

endmodule

//--- logic/peripheral_subsystem.sv
// Peripheral subsystem top: crossbar, PLIC, GPIO and timer
// Interrupt source vector assembly

`timescale 1ns/1ns

module peripheral_subsystem (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  periph_pkg::bus_req_t              bus_req_i,
  output periph_pkg::bus_rsp_t              bus_rsp_o,
  input  logic [periph_pkg::NEXT_INT-1:0]   intr_ext_i,
  output logic                              irq_o,
  output logic                              msip_o,
  input  logic [periph_pkg::GPIO_W-1:0]     gpio_i,
  output logic [periph_pkg::GPIO_W-1:0]     gpio_o,
  output logic [periph_pkg::GPIO_W-1:0]     gpio_oe_o,
  output logic                              timer_intr_o
);

  periph_pkg::reg_req_t reg_req;

  logic                           plic_sel;
  logic                           gpio_sel;
  logic                           tmr_sel;
  logic [periph_pkg::BUS_DW-1:0]  plic_rdata;
  logic [periph_pkg::BUS_DW-1:0]  gpio_rdata;
  logic [periph_pkg::BUS_DW-1:0]  tmr_rdata;
  logic [periph_pkg::GPIO_W-1:0]  gpio_intr;
  logic [periph_pkg::NUM_SRC-1:0] intr_src;

  // Ids: 0 tied low, 1..16 GPIO, 17 timer, 18..21 external
  assign intr_src = {intr_ext_i, timer_intr_o, gpio_intr, 1'b0};

  periph_xbar xbar_i (
    .clk_i,
    .rst_i,
    .bus_req_i,
    .bus_rsp_o,
    .reg_req_o   (reg_req),
    .plic_sel_o  (plic_sel),
    .gpio_sel_o  (gpio_sel),
    .tmr_sel_o   (tmr_sel),
    .plic_rdata_i(plic_rdata),
    .gpio_rdata_i(gpio_rdata),
    .tmr_rdata_i (tmr_rdata)
  );

  periph_plic plic_i (
    .clk_i,
    .rst_i,
    .reg_req_i (reg_req),
    .sel_i     (plic_sel),
    .intr_src_i(intr_src),
    .rdata_o   (plic_rdata),
    .irq_o,
    .msip_o
  );

  periph_gpio gpio_i0 (
    .clk_i,
    .rst_i,
    .reg_req_i  (reg_req),
    .sel_i      (gpio_sel),
    .gpio_i,
    .rdata_o    (gpio_rdata),
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o(gpio_intr)
  );

  periph_timer timer_i (
    .clk_i,
    .rst_i,
    .reg_req_i(reg_req),
    .sel_i    (tmr_sel),
    .rdata_o  (tmr_rdata),
    .timer_intr_o
  );

endmodule

//--- peripheral_subsystem.f
logic/periph_pkg.sv
logic/periph_xbar.sv
logic/periph_plic.sv
logic/periph_gpio.sv
logic/periph_timer.sv
logic/peripheral_subsystem.sv
dv/peripheral_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
  -f peripheral_subsystem.f \
  --top-module peripheral_subsystem_tb \
  -o peripheral_subsystem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/peripheral_subsystem_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
